// File: Makefile
VERILATOR = verilator
TOP = tb_exp2
FILELIST = tb.f
OBJ_DIR = obj_dir
SIM_FLAGS = --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: exp2_ctrl.sv
// Stream handshake controller
module exp2_ctrl #(
	parameter int stages_per_cycle = 4
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	output logic out_valid,
	input logic out_ready,
	output exp2_pkg::word_t out_data,
	input exp2_pkg::word_t result,
	output logic load,
	output logic iter_en,
	output logic [exp2_pkg::digit_w-1:0] digit_base,
	output logic scale_en
);

	// First digit of the final iteration cycle
	localparam int last_base = exp2_pkg::digits - stages_per_cycle;
	localparam logic [exp2_pkg::digit_w-1:0] digit_step =
		stages_per_cycle[exp2_pkg::digit_w-1:0];

	exp2_pkg::ctrl_state_t state;
	logic out_fire;
	logic last_step;

	assign in_ready = (state == exp2_pkg::st_idle);
	assign load = in_valid && in_ready;
	assign iter_en = (state == exp2_pkg::st_iter);
	assign scale_en = (state == exp2_pkg::st_scale);
	assign out_fire = out_valid && out_ready;
	assign last_step = (int'(digit_base) == last_base);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= exp2_pkg::st_idle;
			digit_base <= '0;
		end else begin
			case (state)
				exp2_pkg::st_idle: begin
					if (load) begin
						state <= exp2_pkg::st_iter;
						digit_base <= '0;
					end
				end
				exp2_pkg::st_iter: begin
					if (last_step) begin
						state <= exp2_pkg::st_scale;
						digit_base <= '0;
					end else begin
						digit_base <= digit_base + digit_step;
					end
				end
				exp2_pkg::st_scale: begin
					state <= exp2_pkg::st_hold;
				end
				exp2_pkg::st_hold: begin
					if (out_fire) begin
						state <= exp2_pkg::st_idle;
					end
				end
				default: begin
					state <= exp2_pkg::st_idle;
				end
			endcase
		end
	end

	// Output word and its valid flag, held until taken
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data <= '0;
		end else begin
			if (scale_en) begin
				out_data <= result;
			end
			// Valid rises one cycle into the hold state
			out_valid <= (state == exp2_pkg::st_hold) && !out_fire;
		end
	end

endmodule

// File: exp2_frac_iter.sv
// Fraction normalization iterator
module exp2_frac_iter #(
	parameter int stages_per_cycle = 4
) (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic iter_en,
	input logic [exp2_pkg::digit_w-1:0] digit_base,
	input logic [exp2_pkg::frac_w-1:0] frac_init,
	output exp2_pkg::acc_t prod
);

	// Fraction moves up to the accumulator binary point
	localparam int align = exp2_pkg::acc_frac_w - exp2_pkg::frac_w;

	exp2_pkg::acc_t residual;
	exp2_pkg::acc_t res_chain [stages_per_cycle+1];
	exp2_pkg::acc_t prod_chain [stages_per_cycle+1];

	assign res_chain[0] = residual;
	assign prod_chain[0] = prod;

	// One digit per stage, chained within the cycle
	for (genvar j = 0; j < stages_per_cycle; j++) begin : g_stage
		logic [exp2_pkg::digit_w-1:0] digit;
		logic [exp2_pkg::digit_w:0] shift;
		exp2_pkg::acc_t log_val;
		logic take;

		assign digit = digit_base + (exp2_pkg::digit_w)'(j);
		// Table index is k-1
		assign shift = {1'b0, digit} + 1'b1;

		exp2_log_rom u_rom (
			.digit(digit),
			.value(log_val)
		);

		assign take = (res_chain[j] >= log_val);

		always_comb begin
			if (take) begin
				res_chain[j+1] = res_chain[j] - log_val;
				// Multiply by (1 + 2^-k)
				prod_chain[j+1] = prod_chain[j] + (prod_chain[j] >> shift);
			end else begin
				res_chain[j+1] = res_chain[j];
				prod_chain[j+1] = prod_chain[j];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			residual <= '0;
			prod <= '0;
		end else if (load) begin
			residual <= exp2_pkg::acc_t'(frac_init) << align;
			prod <= exp2_pkg::prod_one;
		end else if (iter_en) begin
			residual <= res_chain[stages_per_cycle];
			prod <= prod_chain[stages_per_cycle];
		end
	end

endmodule

// File: exp2_log_rom.sv
// Logarithm constant table
module exp2_log_rom (
	input logic [exp2_pkg::digit_w-1:0] digit,
	output exp2_pkg::acc_t value
);

	// Entry k-1 holds log2(1 + 2^-k) with 32 fraction bits, rounded
	always_comb begin
		case (digit)
			5'd0: value = 40'h00_95C0_1A3A;
			5'd1: value = 40'h00_5269_E12F;
			5'd2: value = 40'h00_2B80_3474;
			5'd3: value = 40'h00_1663_F6FB;
			5'd4: value = 40'h00_0B5D_69BB;
			5'd5: value = 40'h00_05B9_E5A1;
			5'd6: value = 40'h00_02DF_CA17;
			5'd7: value = 40'h00_0170_9C47;
			5'd8: value = 40'h00_00B8_7C20;
			5'd9: value = 40'h00_005C_4995;
			5'd10: value = 40'h00_002E_27AC;
			5'd11: value = 40'h00_0017_148F;
			5'd12: value = 40'h00_000B_8A76;
			5'd13: value = 40'h00_0005_C546;
			5'd14: value = 40'h00_0002_E2A6;
			5'd15: value = 40'h00_0001_7154;
			// From here on the entries track 2^(32-k) / ln 2
			5'd16: value = 40'h00_0000_B8AA;
			5'd17: value = 40'h00_0000_5C55;
			5'd18: value = 40'h00_0000_2E2B;
			5'd19: value = 40'h00_0000_1715;
			5'd20: value = 40'h00_0000_0B8B;
			5'd21: value = 40'h00_0000_05C5;
			5'd22: value = 40'h00_0000_02E3;
			5'd23: value = 40'h00_0000_0171;
			5'd24: value = 40'h00_0000_00B9;
			5'd25: value = 40'h00_0000_005C;
			5'd26: value = 40'h00_0000_002E;
			5'd27: value = 40'h00_0000_0017;
			5'd28: value = 40'h00_0000_000C;
			5'd29: value = 40'h00_0000_0006;
			5'd30: value = 40'h00_0000_0003;
			5'd31: value = 40'h00_0000_0001;
			default: value = '0;
		endcase
	end

endmodule

// File: exp2_pkg.sv
// Exponential unit shared definitions
package exp2_pkg;

	// Operand Q7.24 signed, result Q8.24 unsigned
	localparam int data_w = 32;
	localparam int frac_w = 24;
	localparam int int_w = 8;

	// Residual and product carry 32 fraction bits
	localparam int acc_w = 40;
	localparam int acc_frac_w = 32;

	// Digit count, one table entry per digit
	localparam int digits = 32;
	localparam int digit_w = $clog2(digits);

	typedef logic [data_w-1:0] word_t;
	typedef logic [acc_w-1:0] acc_t;
	typedef logic [int_w-1:0] shamt_t;

	// 1.0 at the accumulator binary point
	localparam acc_t prod_one = acc_t'(1) << acc_frac_w;

	typedef enum logic [1:0] {
		st_idle,
		st_iter,
		st_scale,
		st_hold
	} ctrl_state_t;

endpackage

// File: exp2_scale.sv
// Operand split and result scaling
module exp2_scale (
	input logic clk,
	input logic rst_n,
	input logic load,
	input exp2_pkg::word_t in_data,
	output logic [exp2_pkg::frac_w-1:0] frac_init,
	input exp2_pkg::acc_t prod,
	output exp2_pkg::word_t result
);

	// Product bits that line up with Q8.24
	localparam int lsb = exp2_pkg::acc_frac_w - exp2_pkg::frac_w;

	logic neg;
	exp2_pkg::shamt_t shamt;
	exp2_pkg::shamt_t int_part;
	exp2_pkg::word_t mant;

	// Two's complement keeps the fraction positive for either sign
	assign frac_init = in_data[exp2_pkg::frac_w-1:0];
	assign int_part = in_data[exp2_pkg::data_w-1 -: exp2_pkg::int_w];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			neg <= 1'b0;
			shamt <= '0;
		end else if (load) begin
			neg <= in_data[exp2_pkg::data_w-1];
			// Negative floor becomes a right shift by its magnitude
			if (in_data[exp2_pkg::data_w-1]) begin
				shamt <= -int_part;
			end else begin
				shamt <= int_part;
			end
		end
	end

	assign mant = prod[lsb +: exp2_pkg::data_w];

	always_comb begin
		if (neg) begin
			result = mant >> shamt;
		end else begin
			result = mant << shamt;
		end
	end

endmodule

// File: exp2_top.sv
// Base-2 exponential unit
module exp2_top #(
	parameter int stages_per_cycle = 4
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input exp2_pkg::word_t in_data,
	output logic out_valid,
	input logic out_ready,
	output exp2_pkg::word_t out_data
);

	logic load;
	logic iter_en;
	logic scale_en;
	logic [exp2_pkg::digit_w-1:0] digit_base;
	logic [exp2_pkg::frac_w-1:0] frac_init;
	exp2_pkg::acc_t prod;
	exp2_pkg::word_t result;

	exp2_ctrl #(
		.stages_per_cycle(stages_per_cycle)
	) u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data),
		.result(result),
		.load(load),
		.iter_en(iter_en),
		.digit_base(digit_base),
		.scale_en(scale_en)
	);

	exp2_frac_iter #(
		.stages_per_cycle(stages_per_cycle)
	) u_frac (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.iter_en(iter_en),
		.digit_base(digit_base),
		.frac_init(frac_init),
		.prod(prod)
	);

	exp2_scale u_scale (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.in_data(in_data),
		.frac_init(frac_init),
		.prod(prod),
		.result(result)
	);

endmodule

// File: tb.f
exp2_pkg.sv
exp2_log_rom.sv
exp2_frac_iter.sv
exp2_scale.sv
exp2_ctrl.sv
exp2_top.sv
tb_exp2_asserts.sv
tb_exp2.sv

// File: tb_exp2.sv
// Exponential unit testbench
module tb_exp2;

	localparam int wait_limit = 100;
	localparam int latency = 10;
	localparam int random_count = 40;
	localparam real one_q24 = 16777216.0;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	exp2_pkg::word_t in_data;
	logic out_valid;
	logic out_ready;
	exp2_pkg::word_t out_data;

	int cycle = 0;

	// Vector table with one row per operand
	string vec_name[$];
	exp2_pkg::word_t vec_in[$];
	exp2_pkg::word_t vec_exp[$];
	int vec_hold[$];

	exp2_top #(
		.stages_per_cycle(4)
	) uut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(in_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic stop_on_failure();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_problem(input string why);
		$display("%s", why);
		stop_on_failure();
	endtask

	task automatic report_mismatch(input string test, input string expected, input string actual);
		$display("** Error: %s: expected %s, actual %s", test, expected, actual);
		stop_on_failure();
	endtask

	// Tolerance is 4 LSB plus 2^-21 of the expected value
	task automatic check_word(input string test, input exp2_pkg::word_t expected,
			input exp2_pkg::word_t actual, input bit exact);
		longint diff;
		real tol;
		diff = longint'(actual) - longint'(expected);
		if (diff < 0) begin
			diff = -diff;
		end
		tol = exact ? 0.0 : 4.0 + real'(expected) / 2097152.0;
		if ($isunknown(actual) || real'(diff) > tol) begin
			report_mismatch(test, $sformatf("%h", expected), $sformatf("%h", actual));
		end
	endtask

	task automatic check_flag(input string test, input logic expected, input logic actual);
		if (actual !== expected) begin
			report_mismatch(test, $sformatf("%b", expected), $sformatf("%b", actual));
		end
	endtask

	function automatic real from_q724(input exp2_pkg::word_t w);
		return real'($signed(w)) / one_q24;
	endfunction

	function automatic exp2_pkg::word_t to_q724(input real x);
		return exp2_pkg::word_t'(longint'($floor(x * one_q24)));
	endfunction

	// Reference 2^x truncated to Q8.24
	function automatic exp2_pkg::word_t ref_exp2(input real x);
		real v;
		v = $pow(2.0, x) * one_q24;
		return exp2_pkg::word_t'(longint'($floor(v)));
	endfunction

	task automatic add_vector(input string name, input exp2_pkg::word_t op, input int hold);
		vec_name.push_back(name);
		vec_in.push_back(op);
		vec_exp.push_back(ref_exp2(from_q724(op)));
		vec_hold.push_back(hold);
	endtask

	task automatic build_table();
		int op;
		int hold;
		add_vector("zero", to_q724(0.0), -1);
		add_vector("one", to_q724(1.0), -1);
		add_vector("three", to_q724(3.0), -1);
		add_vector("minus_one", to_q724(-1.0), -1);
		add_vector("minus_four", to_q724(-4.0), -1);
		add_vector("half", to_q724(0.5), -1);
		add_vector("minus_half", to_q724(-0.5), -1);
		for (int i = 0; i < random_count; i++) begin
			// Operand in [-16, 7)
			op = int'($urandom % 32'd385875968) - 268435456;
			// Even rows stall the output and odd rows run back to back
			hold = (i % 2 == 0) ? int'($urandom % 21) : -1;
			add_vector($sformatf("random_%0d", i), exp2_pkg::word_t'(op), hold);
		end
	endtask

	// Runs from a falling edge to the falling edge after the output transfer
	task automatic run_vector(input int i);
		exp2_pkg::word_t held;
		int waited;
		int c0;
		string name;
		name = vec_name[i];
		in_valid = 1'b1;
		in_data = vec_in[i];
		waited = 0;
		while (in_ready !== 1'b1) begin
			@(negedge clk);
			waited++;
			if (waited > wait_limit) begin
				report_problem($sformatf("%s: the unit never accepted the operand", name));
			end
		end
		c0 = cycle + 1;
		out_ready = (vec_hold[i] < 0);
		@(negedge clk);
		// Next operand goes up at once and must wait for the output transfer
		if (i + 1 < vec_in.size()) begin
			in_data = vec_in[i+1];
		end else begin
			in_valid = 1'b0;
			in_data = '0;
		end
		waited = 0;
		while (out_valid !== 1'b1) begin
			check_flag({name, "_busy_in_ready"}, 1'b0, in_ready);
			@(negedge clk);
			waited++;
			if (waited > wait_limit) begin
				report_problem($sformatf("%s: no result came out of the unit", name));
			end
		end
		if (cycle - c0 != latency) begin
			report_mismatch({name, "_latency"}, $sformatf("%0d", latency),
				$sformatf("%0d", cycle - c0));
		end
		check_word(name, vec_exp[i], out_data, 1'b0);
		held = out_data;
		for (int h = 0; h < vec_hold[i]; h++) begin
			@(negedge clk);
			check_flag({name, "_stall_out_valid"}, 1'b1, out_valid);
			check_flag({name, "_stall_in_ready"}, 1'b0, in_ready);
			check_word({name, "_stall_out_data"}, held, out_data, 1'b1);
		end
		out_ready = 1'b1;
		@(negedge clk);
		// Output taken on the edge just passed
		check_flag({name, "_done_out_valid"}, 1'b0, out_valid);
		check_flag({name, "_done_in_ready"}, 1'b1, in_ready);
	endtask

	initial begin
		int seed_ret;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		seed_ret = $urandom(32'hc4eff876);
		build_table();

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_flag("reset_in_ready", 1'b1, in_ready);
		check_flag("reset_out_valid", 1'b0, out_valid);

		for (int i = 0; i < vec_in.size(); i++) begin
			run_vector(i);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: tb_exp2_asserts.sv
// Stream handshake assertions
module tb_exp2_asserts (
	input logic clk,
	input logic rst_n,
	input logic in_ready,
	input logic out_valid,
	input logic out_ready,
	input exp2_pkg::word_t out_data
);

	// Stalled output keeps its word
	property p_out_stable;
		@(posedge clk) disable iff (!rst_n)
			out_valid && !out_ready |=> out_valid && $stable(out_data);
	endproperty

	// One operand in flight
	property p_no_accept_while_valid;
		@(posedge clk) disable iff (!rst_n)
			out_valid |-> !in_ready;
	endproperty

	property p_reset_clears_valid;
		@(posedge clk)
			!rst_n |=> !out_valid;
	endproperty

	a_out_stable: assert property (p_out_stable)
		else $error("out_valid or out_data changed while out_ready was low");

	a_no_accept_while_valid: assert property (p_no_accept_while_valid)
		else $error("in_ready was high while out_valid was high");

	a_reset_clears_valid: assert property (p_reset_clears_valid)
		else $error("out_valid was high after reset");

endmodule

bind exp2_ctrl tb_exp2_asserts u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.in_ready(in_ready),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_data(out_data)
);
